// File: common/rv32_decode_pkg.sv
// ==========================================================
// RV32I base opcodes only. No compressed or CSR field decode
// Instruction word has an R view and an I view of one word
// ==========================================================

package rv32_decode_pkg;

  // ==========================================================
  // Major opcodes, instruction bits 6 to 2
  // ==========================================================
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_OPIMM  = 5'b00100;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_SYSTEM = 5'b11100;

  // ==========================================================
  // ALU operations, funct7 bit 5 joined to funct3
  // ==========================================================
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SUB  = 4'b1000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_SRA  = 4'b1101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  // Branch conditions by funct3
  localparam logic [2:0] BR_EQ  = 3'b000;
  localparam logic [2:0] BR_NE  = 3'b001;
  localparam logic [2:0] BR_LT  = 3'b100;
  localparam logic [2:0] BR_GE  = 3'b101;
  localparam logic [2:0] BR_LTU = 3'b110;
  localparam logic [2:0] BR_GEU = 3'b111;

  // Operand constants
  localparam logic [31:0] WORD_ZERO = 32'h0000_0000;
  localparam logic [31:0] WORD_FOUR = 32'h0000_0004;

  // Architectural register count, x0 included
  localparam int REG_COUNT = 32;

  // One instruction word, read as R-type or as I/S-type fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_word_u;

endpackage

// File: decode/branch_compare.sv
// ==========================================================
// Combinational branch condition for RV32I funct3 codes
// Codes 010 and 011 are undefined and never taken
// ==========================================================

`timescale 1ns/1ps

module branch_compare (
  input  logic [2:0]  op,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  output logic        branch
);

  import rv32_decode_pkg::*;

  logic is_eq;
  logic is_lt;
  logic is_ltu;

  // Shared comparators for all six conditions
  assign is_eq  = (rs1 == rs2);
  assign is_lt  = ($signed(rs1) < $signed(rs2));
  assign is_ltu = (rs1 < rs2);

  always_comb begin
    case (op)
      BR_EQ:   branch = is_eq;
      BR_NE:   branch = ~is_eq;
      BR_LT:   branch = is_lt;
      BR_GE:   branch = ~is_lt;
      BR_LTU:  branch = is_ltu;
      BR_GEU:  branch = ~is_ltu;
      // Reserved encodings
      default: branch = 1'b0;
    endcase
  end

endmodule

// File: rtl/imm_gen.sv
// ==========================================================
// Sign-extended immediate, format chosen by major opcode
// Opcodes without an immediate give zero
// ==========================================================

`timescale 1ns/1ps

module imm_gen (
  input  logic [31:0] ir,
  output logic [31:0] immediate
);

  import rv32_decode_pkg::*;

  instr_word_u ir_w;
  logic [4:0]  opc;
  logic        sign;

  assign ir_w = ir;
  assign opc  = ir_w.r.opcode[6:2];
  // Bit 31 is the sign for every format
  assign sign = ir[31];

  always_comb begin
    case (opc)
      // I format, also the CSR address of SYSTEM
      OPC_JALR, OPC_LOAD, OPC_OPIMM, OPC_SYSTEM: begin
        immediate = {{20{sign}}, ir_w.i.imm12};
      end
      // S format, split across funct7 and rd slots
      OPC_STORE: begin
        immediate = {{20{sign}}, ir_w.r.funct7, ir_w.r.rd};
      end
      // B format, halfword offset
      OPC_BRANCH: begin
        immediate = {{19{sign}}, sign, ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      // U format, upper 20 bits
      OPC_LUI, OPC_AUIPC: begin
        immediate = {ir[31:12], 12'h000};
      end
      // J format, halfword offset
      OPC_JAL: begin
        immediate = {{11{sign}}, sign, ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

// File: rtl/reg_file.sv
// ==========================================================
// 31 registers plus hardwired x0, two async read ports
// Same-cycle write is forwarded to both read ports
// ==========================================================

`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        rstz,
  input  logic [4:0]  rs1_sel,
  input  logic [4:0]  rs2_sel,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        regwr_en,
  input  logic [4:0]  regwr_sel,
  input  logic [31:0] regwr_data
);

  import rv32_decode_pkg::*;

  // x0 has no storage
  logic [31:0] regs [1:REG_COUNT-1];

  // One read port with x0 and forwarding
  function automatic logic [31:0] read_port(input logic [4:0] sel);
    logic [31:0] val;
    if (sel == 5'd0) begin
      val = '0;
    end else if (regwr_en && regwr_sel == sel) begin
      // Write in flight wins over stored value
      val = regwr_data;
    end else begin
      val = regs[sel];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_sel);
    rs2_data = read_port(rs2_sel);
  end

  // ==========================================================
  // Write port
  // ==========================================================
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regwr_en && regwr_sel != 5'd0) begin
      regs[regwr_sel] <= regwr_data;
    end
  end

  // Writeback source must present a defined target
  a_wr_sel_known: assert property (
    @(posedge clk) disable iff (!rstz)
    regwr_en |-> !$isunknown(regwr_sel)
  ) else $error("reg_file: regwr_sel unknown with regwr_en high");

endmodule

// File: decode/instr_decode.sv
// ==========================================================
// Decode stage with one output register, never stalls
// Flush on an edge drops both held result and offered word
// ==========================================================

`timescale 1ns/1ps

module instr_decode (
  input  logic        clk,
  input  logic        rstz,
  input  logic        flush,
  // Fetch side
  input  logic [31:0] fetch_pc,
  input  logic [31:0] fetch_ir,
  input  logic        fetch_vld,
  output logic        fetch_rdy,
  // From immediate generator and register file
  input  logic [31:0] immediate,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  // Execute side
  output logic        decode_vld,
  input  logic        decode_rdy,
  output logic [31:0] decode_pc,
  output logic [31:0] decode_ir,
  output logic [3:0]  decode_aluop,
  output logic [31:0] decode_op1,
  output logic [31:0] decode_op2,
  output logic [31:0] decode_addr,
  output logic        decode_regwr_alu,
  output logic        decode_jump,
  output logic        decode_branch,
  output logic        decode_illegal
);

  import rv32_decode_pkg::*;

  instr_word_u ir;
  logic [4:0]  opc;
  logic [2:0]  funct3;

  logic [3:0]  aluop;
  logic [31:0] op1;
  logic [31:0] op2;

  // Address generation
  logic [31:0] base;
  logic [31:0] offset;
  logic [31:0] addr_raw;
  logic [31:0] addr;
  logic        align;

  logic        regwr_alu;
  logic        is_jump;
  logic        br_taken;
  logic        opc_known;
  logic        illegal;
  logic        xfer;

  // ==========================================================
  // Field extraction
  // ==========================================================
  assign ir     = fetch_ir;
  assign opc    = ir.r.opcode[6:2];
  assign funct3 = ir.r.funct3;

  // ==========================================================
  // Operation and operand select
  // ==========================================================
  always_comb begin
    // Default is link value pc + 4
    aluop  = ALU_ADD;
    op1    = fetch_pc;
    op2    = WORD_FOUR;
    align  = 1'b0;
    base   = fetch_pc;
    offset = WORD_FOUR;

    case (opc)
      OPC_LUI: begin
        op1 = WORD_ZERO;
        op2 = immediate;
      end
      OPC_AUIPC: begin
        op2 = immediate;
      end
      OPC_JAL: begin
        offset = immediate;
      end
      OPC_JALR: begin
        // Target is register relative, LSB forced low
        align  = 1'b1;
        base   = rs1_data;
        offset = immediate;
      end
      OPC_BRANCH: begin
        offset = immediate;
      end
      OPC_OPIMM: begin
        // Only shifts carry an op modifier in the immediate
        if (funct3 == ALU_SLL[2:0] || funct3 == ALU_SRL[2:0]) begin
          aluop = {ir.r.funct7[5], funct3};
        end else begin
          aluop = {1'b0, funct3};
        end
        op1 = rs1_data;
        op2 = immediate;
      end
      OPC_OP: begin
        aluop = {ir.r.funct7[5], funct3};
        op1   = rs1_data;
        op2   = rs2_data;
      end
      default: begin
      end
    endcase
  end

  // Single adder for jump and branch targets
  assign addr_raw = base + offset;
  assign addr     = {addr_raw[31:1], addr_raw[0] & ~align};

  // ==========================================================
  // Flags
  // ==========================================================
  always_comb begin
    case (opc)
      OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OPIMM, OPC_OP: regwr_alu = 1'b1;
      default: regwr_alu = 1'b0;
    endcase
  end

  assign is_jump = (opc == OPC_JAL) || (opc == OPC_JALR);

  // Legal major opcodes of this decoder
  always_comb begin
    case (opc)
      OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
      OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP, OPC_SYSTEM: opc_known = 1'b1;
      default: opc_known = 1'b0;
    endcase
  end

  // 16-bit encodings have low opcode bits other than 11
  assign illegal = ~opc_known | (ir.r.opcode[1:0] != 2'b11);

  branch_compare u_branch (
    .op    (funct3),
    .rs1   (rs1_data),
    .rs2   (rs2_data),
    .branch(br_taken)
  );

  // ==========================================================
  // Output register and handshake
  // ==========================================================
  assign fetch_rdy = ~decode_vld | decode_rdy;
  assign xfer      = fetch_vld & fetch_rdy;

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      decode_vld <= 1'b0;
    end else if (flush) begin
      decode_vld <= 1'b0;
    end else if (xfer) begin
      decode_vld <= 1'b1;
    end else if (decode_rdy) begin
      decode_vld <= 1'b0;
    end
  end

  // Payload loads only on an accepted word
  always_ff @(posedge clk) begin
    if (xfer && !flush) begin
      decode_pc        <= fetch_pc;
      decode_ir        <= fetch_ir;
      decode_aluop     <= aluop;
      decode_op1       <= op1;
      decode_op2       <= op2;
      decode_addr      <= addr;
      decode_regwr_alu <= regwr_alu & (ir.r.rd != 5'd0);
      decode_jump      <= is_jump;
      decode_branch    <= br_taken & (opc == OPC_BRANCH);
      decode_illegal   <= illegal;
    end
  end

  // Held result must not change under back-pressure
  a_payload_hold: assert property (
    @(posedge clk) disable iff (!rstz)
    (decode_vld && !decode_rdy) |=>
      $stable({decode_pc, decode_ir, decode_aluop, decode_op1, decode_op2,
               decode_addr, decode_regwr_alu, decode_jump, decode_branch,
               decode_illegal})
  ) else $error("instr_decode: payload changed while stalled");

endmodule

// File: rtl/decode_top.sv
// ==========================================================
// Decode stage top, result one cycle after fetch transfer
// Writeback port is external and forwarded in the same cycle
// ==========================================================

`timescale 1ns/1ps

module decode_top (
  input  logic        clk,
  input  logic        rstz,
  input  logic        flush,
  // Fetch side
  input  logic [31:0] fetch_pc,
  input  logic [31:0] fetch_ir,
  input  logic        fetch_vld,
  output logic        fetch_rdy,
  // Execute side
  output logic        decode_vld,
  input  logic        decode_rdy,
  output logic [31:0] decode_pc,
  output logic [31:0] decode_ir,
  output logic [3:0]  decode_aluop,
  output logic [31:0] decode_op1,
  output logic [31:0] decode_op2,
  output logic [31:0] decode_addr,
  output logic        decode_regwr_alu,
  output logic        decode_jump,
  output logic        decode_branch,
  output logic        decode_illegal,
  // Writeback
  input  logic        regwr_en,
  input  logic [4:0]  regwr_sel,
  input  logic [31:0] regwr_data
);

  logic [31:0] immediate;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  // Source selects straight from rs1 and rs2 fields
  reg_file u_regs (
    .clk       (clk),
    .rstz      (rstz),
    .rs1_sel   (fetch_ir[19:15]),
    .rs2_sel   (fetch_ir[24:20]),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .regwr_en  (regwr_en),
    .regwr_sel (regwr_sel),
    .regwr_data(regwr_data)
  );

  imm_gen u_imm (
    .ir       (fetch_ir),
    .immediate(immediate)
  );

  instr_decode u_decode (
    .clk             (clk),
    .rstz            (rstz),
    .flush           (flush),
    .fetch_pc        (fetch_pc),
    .fetch_ir        (fetch_ir),
    .fetch_vld       (fetch_vld),
    .fetch_rdy       (fetch_rdy),
    .immediate       (immediate),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .decode_vld      (decode_vld),
    .decode_rdy      (decode_rdy),
    .decode_pc       (decode_pc),
    .decode_ir       (decode_ir),
    .decode_aluop    (decode_aluop),
    .decode_op1      (decode_op1),
    .decode_op2      (decode_op2),
    .decode_addr     (decode_addr),
    .decode_regwr_alu(decode_regwr_alu),
    .decode_jump     (decode_jump),
    .decode_branch   (decode_branch),
    .decode_illegal  (decode_illegal)
  );

endmodule

// File: test/decode_checker.sv
// ============================================================
// Compares each decode handshake with the oldest expected item
// Expected items are pushed by the testbench into exp_q
// ============================================================

`timescale 1ns/1ps

module decode_checker (
  input logic        clk,
  input logic        rstz,
  input logic        fetch_rdy,
  input logic        decode_vld,
  input logic        decode_rdy,
  input logic [31:0] decode_pc,
  input logic [31:0] decode_ir,
  input logic [3:0]  decode_aluop,
  input logic [31:0] decode_op1,
  input logic [31:0] decode_op2,
  input logic [31:0] decode_addr,
  input logic        decode_regwr_alu,
  input logic        decode_jump,
  input logic        decode_branch,
  input logic        decode_illegal
);

  // pc, ir, aluop, op1, op2, addr, then four flags
  logic [167:0] exp_q[$];
  int           error_count = 0;
  int           check_count = 0;

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    logic [167:0] e;
    if (rstz) begin
      // Fetch may proceed when the output register is empty or drains
      check_word("fetch_rdy", {31'h0, ~decode_vld | decode_rdy}, {31'h0, fetch_rdy});
    end
    if (rstz && decode_vld && decode_rdy) begin
      if (exp_q.size() == 0) begin
        $display("Decode result at %0t ns with no instruction expected", $time);
        error_count++;
      end else begin
        e = exp_q.pop_front();
        check_count++;
        check_word("decode_pc", e[167:136], decode_pc);
        check_word("decode_ir", e[135:104], decode_ir);
        check_word("decode_aluop", {28'h0, e[103:100]}, {28'h0, decode_aluop});
        check_word("decode_op1", e[99:68], decode_op1);
        check_word("decode_op2", e[67:36], decode_op2);
        check_word("decode_addr", e[35:4], decode_addr);
        check_word("decode_regwr_alu", {31'h0, e[3]}, {31'h0, decode_regwr_alu});
        check_word("decode_jump", {31'h0, e[2]}, {31'h0, decode_jump});
        check_word("decode_branch", {31'h0, e[1]}, {31'h0, decode_branch});
        check_word("decode_illegal", {31'h0, e[0]}, {31'h0, decode_illegal});
      end
    end
  end

endmodule

// File: test/tb_decode.sv
// ============================================================
// File driven decode testbench, inputs change on falling edge
// Random decode_rdy, each wait gives up after 200 cycles
// ============================================================

`timescale 1ns/1ps

module tb_decode;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        rstz;
  logic        flush;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_ir;
  logic        fetch_vld;
  logic        fetch_rdy;
  logic        decode_vld;
  logic        decode_rdy;
  logic [31:0] decode_pc;
  logic [31:0] decode_ir;
  logic [3:0]  decode_aluop;
  logic [31:0] decode_op1;
  logic [31:0] decode_op2;
  logic [31:0] decode_addr;
  logic        decode_regwr_alu;
  logic        decode_jump;
  logic        decode_branch;
  logic        decode_illegal;
  logic        regwr_en;
  logic [4:0]  regwr_sel;
  logic [31:0] regwr_data;

  integer      seed;
  integer      fd;
  string       line;
  string       test_name;
  int          bad_records;
  int          err_base;
  int          tests_passed;
  int          tests_failed;
  logic        in_test;
  logic        timed_out;
  // Write held back to share a cycle with the next instruction
  logic        wr_pending;
  logic [4:0]  wr_sel;
  logic [31:0] wr_data;

  decode_top u_dut (.*);

  decode_checker u_check (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles: %s", TIMEOUT, what);
    timed_out = 1'b1;
  endtask

  task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
    @(negedge clk);
    fetch_vld  = 1'b0;
    regwr_en   = 1'b1;
    regwr_sel  = sel;
    regwr_data = data;
    @(posedge clk);
  endtask

  task automatic issue(input logic [31:0] pc, input logic [31:0] ir,
                       input logic [167:0] exp);
    int          waited;
    logic        accepted;
    logic [31:0] r;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < TIMEOUT) begin
      @(negedge clk);
      fetch_pc  = pc;
      fetch_ir  = ir;
      fetch_vld = 1'b1;
      if (waited == 0 && wr_pending) begin
        // Ready forced so the transfer meets the write
        regwr_en   = 1'b1;
        regwr_sel  = wr_sel;
        regwr_data = wr_data;
        decode_rdy = 1'b1;
        wr_pending = 1'b0;
      end else begin
        regwr_en   = 1'b0;
        r          = $random(seed);
        decode_rdy = (r[1:0] != 2'b00);
      end
      #1;
      if (fetch_rdy) begin
        accepted = 1'b1;
        u_check.exp_q.push_back(exp);
      end
      @(posedge clk);
      waited++;
    end
    if (!accepted) report_timeout("fetch_rdy stayed low");
  endtask

  // Kill the word accepted on the last edge
  task automatic flush_last();
    @(negedge clk);
    fetch_vld  = 1'b0;
    regwr_en   = 1'b0;
    decode_rdy = 1'b0;
    flush      = 1'b1;
    void'(u_check.exp_q.pop_back());
    @(posedge clk);
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic drain_and_report();
    int   waited;
    logic drained;
    waited  = 0;
    drained = 1'b0;
    while (!drained && waited < TIMEOUT) begin
      @(negedge clk);
      fetch_vld  = 1'b0;
      regwr_en   = 1'b0;
      decode_rdy = 1'b1;
      // Done once nothing is queued or held
      if (u_check.exp_q.size() == 0 && !decode_vld) begin
        drained = 1'b1;
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    if (!drained) begin
      report_timeout("expected results never came out");
      tests_failed++;
    end else if (u_check.error_count == err_base) begin
      $display("Test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors", test_name, u_check.error_count - err_base);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] f[0:9];
    int          n;
    int          last;
    seed = 32'h9e56;
    rstz = 1'b0;
    flush = 1'b0;
    fetch_pc = '0;
    fetch_ir = '0;
    fetch_vld = 1'b0;
    decode_rdy = 1'b0;
    regwr_en = 1'b0;
    regwr_sel = '0;
    regwr_data = '0;
    wr_pending = 1'b0;
    wr_sel = '0;
    wr_data = '0;
    bad_records = 0;
    tests_passed = 0;
    tests_failed = 0;
    in_test = 1'b0;
    timed_out = 1'b0;
    err_base = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstz = 1'b1;

    fd = $fopen("test/decode_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/decode_stimulus.txt");
      bad_records++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() < 1 || line.getc(0) == "#" || line.getc(0) == 8'd10) begin
          continue;
        end
        case (line.getc(0))
          "W": begin
            n = $sscanf(line, "W %h %h %h", f[0], f[1], f[2]);
            if (n != 3) begin
              $display("Malformed write record: %s", line);
              bad_records++;
            end else if (f[2][0]) begin
              wr_pending = 1'b1;
              wr_sel     = f[0][4:0];
              wr_data    = f[1];
            end else begin
              write_reg(f[0][4:0], f[1]);
            end
          end
          "I": begin
            n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n != 10) begin
              $display("Malformed instruction record: %s", line);
              bad_records++;
            end else begin
              issue(f[0], f[1], {f[0], f[1], f[2][3:0], f[3], f[4], f[5],
                                 f[6][0], f[7][0], f[8][0], f[9][0]});
            end
          end
          "F": flush_last();
          "T": begin
            if (in_test) drain_and_report();
            last = line.len() - 1;
            while (last > 2 && (line.getc(last) == 8'd10 || line.getc(last) == 8'd13)) begin
              last--;
            end
            test_name = line.substr(2, last);
            err_base  = u_check.error_count;
            in_test   = 1'b1;
          end
          default: begin
            $display("Unknown record kind: %s", line);
            bad_records++;
          end
        endcase
      end
      $fclose(fd);
      if (in_test && !timed_out) drain_and_report();
    end

    $display("Tests passed %0d, failed %0d, results checked %0d, errors %0d",
             tests_passed, tests_failed, u_check.check_count,
             u_check.error_count + bad_records);
    if (!timed_out && u_check.error_count == 0 && bad_records == 0 &&
        tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: rv32_decode.f
common/rv32_decode_pkg.sv
decode/branch_compare.sv
rtl/imm_gen.sv
rtl/reg_file.sv
decode/instr_decode.sv
rtl/decode_top.sv
test/decode_checker.sv
test/tb_decode.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv32_decode.f \
  --top-module tb_decode -o sim_decode

out=$(./obj_dir/sim_decode)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// File: test/decode_stimulus.txt
# W sel data hold | I pc ir aluop op1 op2 addr regwr jump branch illegal (hex)
# F flushes the previous I | T name starts a test | hold 1 writes with the next I
W 01 00000010 0
W 02 00000003 0
W 03 fffffff0 0
W 04 80000000 0
W 05 7fffffff 0
T alu_ops
I 00000100 00208333 0 00000010 00000003 00000104 1 0 0 0
I 00000104 402083b3 8 00000010 00000003 00000108 1 0 0 0
I 00000108 4021d433 d fffffff0 00000003 0000010c 1 0 0 0
I 0000010c fff08493 0 00000010 ffffffff 00000110 1 0 0 0
I 00000110 4041d513 d fffffff0 00000404 00000114 1 0 0 0
I 00000114 7ff14593 4 00000003 000007ff 00000118 1 0 0 0
I 00000118 0051b633 3 fffffff0 7fffffff 0000011c 1 0 0 0
T control_transfer
I 00000200 123456b7 0 00000000 12345000 00000204 1 0 0 0
I 00000204 fffff717 0 00000204 fffff000 00000208 1 0 0 0
I 00000208 010000ef 0 00000208 00000004 00000218 1 1 0 0
I 0000020c ff9ff06f 0 0000020c 00000004 00000204 0 1 0 0
I 00000210 005087e7 0 00000210 00000004 00000014 1 1 0 0
I 00000214 ffe10067 0 00000214 00000004 00000000 0 1 0 0
T branches
I 00000300 00108463 0 00000300 00000004 00000308 0 0 1 0
I 00000304 00209463 0 00000304 00000004 0000030c 0 0 1 0
I 00000308 0011c463 0 00000308 00000004 00000310 0 0 1 0
I 0000030c 00525463 0 0000030c 00000004 00000314 0 0 0 0
I 00000310 0042e463 0 00000310 00000004 00000318 0 0 1 0
I 00000314 0041f463 0 00000314 00000004 0000031c 0 0 1 0
I 00000318 00208463 0 00000318 00000004 00000320 0 0 0 0
I 0000031c fe30cee3 0 0000031c 00000004 00000318 0 0 0 0
T back_pressure
I 00000400 00100813 0 00000000 00000001 00000404 1 0 0 0
I 00000404 00200813 0 00000000 00000002 00000408 1 0 0 0
I 00000408 00300813 0 00000000 00000003 0000040c 1 0 0 0
I 0000040c 00400813 0 00000000 00000004 00000410 1 0 0 0
T flush
I 00000500 00500813 0 00000000 00000005 00000504 1 0 0 0
I 00000504 00600813 0 00000000 00000006 00000508 1 0 0 0
F
I 00000508 00700813 0 00000000 00000007 0000050c 1 0 0 0
T corner_cases
W 11 000000aa 1
I 00000600 011888b3 0 000000aa 000000aa 00000604 1 0 0 0
I 00000604 00208033 0 00000010 00000003 00000608 0 0 0 0
I 00000608 ffffffff 0 00000608 00000004 0000060c 0 0 0 1
I 0000060c 00000011 0 00000000 00000000 00000610 0 0 0 1
I 00000610 00000073 0 00000610 00000004 00000614 0 0 0 0
